/* rtl/fetch_settings.svh */
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// address split for the instruction cache
`define FETCH_TAG_W      19
`define FETCH_INDEX_W    8
`define FETCH_OFFSET_W   5  // byte offset, 8 words per line

`define FETCH_LINE_WORDS 8

// read bus widths
`define FETCH_ADDR_W     32
`define FETCH_DATA_W     32

`endif

/* rtl/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    // instruction cache FSM
    typedef enum logic [1:0] {
        ic_idle,
        ic_lookup,  // arrays read, tag compare this cycle
        ic_refill,  // eight-beat burst into the victim way
        ic_bypass   // single uncached beat
    } icache_state_t;

    // data read unit FSM
    typedef enum logic [1:0] {
        dru_idle,
        dru_addr,
        dru_data
    } dru_state_t;

    // owner of the shared read bus
    typedef enum logic [1:0] {
        grant_none,
        grant_icache,
        grant_dread
    } arb_grant_t;

endpackage

`default_nettype wire

/* rtl/axi_read_if.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_settings.svh"

interface axi_read_if;

    // address channel
    logic [`FETCH_ADDR_W-1:0] araddr;
    logic [7:0]               arlen;   // beats minus one
    logic [2:0]               arsize;
    logic                     arvalid;
    logic                     arready;

    // data channel
    logic [`FETCH_DATA_W-1:0] rdata;
    logic                     rlast;
    logic                     rvalid;
    logic                     rready;

    modport master (
        output araddr, arlen, arsize, arvalid, rready,
        input  arready, rdata, rlast, rvalid
    );

    modport slave (
        input  araddr, arlen, arsize, arvalid, rready,
        output arready, rdata, rlast, rvalid
    );

endinterface

`default_nettype wire

/* rtl/icache_2way.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_settings.svh"

module icache_2way
    import fetch_pkg::*;
(
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       no_cache,
    input  wire                       inst_en,
    input  wire [`FETCH_ADDR_W-1:0]   pc_next,
    output logic                      stall,
    output logic                      inst_data_ok1,
    output logic                      inst_data_ok2,
    output logic [`FETCH_DATA_W-1:0]  inst_rdata1,
    output logic [`FETCH_DATA_W-1:0]  inst_rdata2,
    axi_read_if.master                bus
);

    localparam int WORD_W = `FETCH_OFFSET_W - 2;
    localparam int SETS   = 1 << `FETCH_INDEX_W;
    localparam int LINE_W = `FETCH_INDEX_W + `FETCH_OFFSET_W;

    icache_state_t state;

    logic [`FETCH_ADDR_W-1:0] pc;   // address of the fetch in flight
    logic                     nc_q; // no_cache sampled with pc
    logic                     done_q;
    logic                     ar_pending;
    logic                     r_wait;
    logic [WORD_W-1:0]        cnt;  // beat number within the burst
    logic                     victim;
    logic [`FETCH_DATA_W-1:0] word1_q;
    logic [`FETCH_DATA_W-1:0] word2_q;

    // registered array outputs, one set per way
    logic [`FETCH_TAG_W-1:0]  tag_q [2];
    logic [1:0]               valid_q;
    logic [`FETCH_DATA_W-1:0] line_q [2][`FETCH_LINE_WORDS];

    logic [SETS-1:0]          valid [2];
    logic [SETS-1:0]          lru;  // names the way to replace next

    logic [`FETCH_TAG_W-1:0]   tag;
    logic [`FETCH_INDEX_W-1:0] index;
    logic [`FETCH_INDEX_W-1:0] index_next;
    logic [WORD_W-1:0]         off1;
    logic [WORD_W-1:0]         off2;
    logic [1:0]                way_hit;
    logic                      hit;
    logic                      hit_way;
    logic                      hit_path;
    logic                      accept;
    logic                      beat;
    logic                      last_beat;
    logic                      fill_we;
    logic                      fill_end;

    assign tag        = pc[`FETCH_ADDR_W-1:LINE_W];
    assign index      = pc[LINE_W-1:`FETCH_OFFSET_W];
    assign index_next = pc_next[LINE_W-1:`FETCH_OFFSET_W];
    assign off1       = pc[`FETCH_OFFSET_W-1:2];
    assign off2       = off1 + 1'b1;  // wraps at the line end, masked by ok2

    assign way_hit[0] = valid_q[0] && (tag_q[0] == tag);
    assign way_hit[1] = valid_q[1] && (tag_q[1] == tag);
    assign hit        = |way_hit;
    assign hit_way    = way_hit[1];
    assign hit_path   = (state == ic_lookup) && !nc_q && hit;

    assign stall  = !((state == ic_idle) || hit_path);
    assign accept = inst_en && !stall;

    assign beat      = bus.rvalid && bus.rready;
    assign last_beat = beat && bus.rlast;
    assign fill_we   = beat && (state == ic_refill);
    assign fill_end  = last_beat && (state == ic_refill);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ic_idle;
            nc_q       <= 1'b0;
            done_q     <= 1'b0;
            ar_pending <= 1'b0;
            r_wait     <= 1'b0;
        end else begin
            done_q <= last_beat;  // ok pulse follows the rlast beat
            if (accept)
                nc_q <= no_cache;
            if (bus.arvalid && bus.arready) begin
                ar_pending <= 1'b0;
                r_wait     <= 1'b1;
            end
            if (last_beat)
                r_wait <= 1'b0;
            case (state)
                ic_idle: begin
                    if (accept)
                        state <= ic_lookup;
                end
                ic_lookup: begin
                    if (nc_q) begin
                        state      <= ic_bypass;
                        ar_pending <= 1'b1;
                    end else if (!hit) begin
                        state      <= ic_refill;
                        ar_pending <= 1'b1;
                    end else if (!accept) begin
                        state <= ic_idle;
                    end
                end
                ic_refill, ic_bypass: begin
                    if (last_beat)
                        state <= ic_idle;
                end
                default: state <= ic_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            pc <= pc_next;
        if (state == ic_lookup) begin
            victim <= lru[index];
            cnt    <= '0;
        end
        if (beat)
            cnt <= cnt + 1'b1;
        // pick the requested words off the burst as they pass
        if (fill_we && (cnt == off1))
            word1_q <= bus.rdata;
        if (fill_we && (cnt == off2) && (off1 != '1))
            word2_q <= bus.rdata;
        if (beat && (state == ic_bypass))
            word1_q <= bus.rdata;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lru      <= '0;
            valid[0] <= '0;
            valid[1] <= '0;
        end else begin
            if (hit_path)
                lru[index] <= ~hit_way;
            if (fill_end) begin
                lru[index]           <= ~victim;
                valid[victim][index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            valid_q <= {valid[1][index_next], valid[0][index_next]};
    end

    for (genvar w = 0; w < 2; w++) begin : g_way
        logic [`FETCH_TAG_W-1:0] tag_mem [SETS];

        always_ff @(posedge clk) begin
            if (fill_end && (victim == 1'(w)))
                tag_mem[index] <= tag;
            if (accept)
                tag_q[w] <= tag_mem[index_next];
        end

        // one bank per word so a whole line reads out at once
        for (genvar b = 0; b < `FETCH_LINE_WORDS; b++) begin : g_bank
            logic [`FETCH_DATA_W-1:0] bank [SETS];

            always_ff @(posedge clk) begin
                if (fill_we && (victim == 1'(w)) && (cnt == WORD_W'(b)))
                    bank[index] <= bus.rdata;
                if (accept)
                    line_q[w][b] <= bank[index_next];
            end
        end
    end

    assign inst_data_ok1 = hit_path || done_q;
    assign inst_data_ok2 = (hit_path || (done_q && !nc_q)) && (off1 != '1);
    assign inst_rdata1   = hit_path ? line_q[hit_way][off1] : word1_q;
    assign inst_rdata2   = hit_path ? line_q[hit_way][off2] : word2_q;

    // burst from the line base, or one word at pc when uncached
    assign bus.araddr  = (state == ic_bypass) ? pc
                                              : {tag, index, {`FETCH_OFFSET_W{1'b0}}};
    assign bus.arlen   = (state == ic_bypass) ? 8'd0 : 8'(`FETCH_LINE_WORDS - 1);
    assign bus.arsize  = 3'd2;  // 4-byte beats
    assign bus.arvalid = ar_pending;
    assign bus.rready  = r_wait;

endmodule

`default_nettype wire

/* rtl/data_read_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_settings.svh"

module data_read_unit
    import fetch_pkg::*;
(
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       load_req,
    input  wire [`FETCH_ADDR_W-1:0]   load_addr,
    output logic                      load_busy,
    output logic                      load_ok,
    output logic [`FETCH_DATA_W-1:0]  load_data,
    axi_read_if.master                bus
);

    dru_state_t               state;
    logic [`FETCH_ADDR_W-1:0] addr_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= dru_idle;
            load_ok <= 1'b0;
        end else begin
            load_ok <= 1'b0;
            case (state)
                dru_idle: begin
                    if (load_req)
                        state <= dru_addr;
                end
                dru_addr: begin
                    if (bus.arready)
                        state <= dru_data;
                end
                dru_data: begin
                    if (bus.rvalid && bus.rlast) begin
                        state   <= dru_idle;
                        load_ok <= 1'b1;  // one cycle after the beat
                    end
                end
                default: state <= dru_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load_req && (state == dru_idle))
            addr_q <= load_addr;
        if (bus.rvalid && bus.rready)
            load_data <= bus.rdata;  // held until the next load returns
    end

    assign load_busy = (state != dru_idle);

    assign bus.araddr  = addr_q;
    assign bus.arlen   = 8'd0;  // single beat
    assign bus.arsize  = 3'd2;
    assign bus.arvalid = (state == dru_addr);
    assign bus.rready  = (state == dru_data);

endmodule

`default_nettype wire

/* rtl/axi_read_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_read_arbiter
    import fetch_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    axi_read_if.slave  m_icache,
    axi_read_if.slave  m_dread,
    axi_read_if.master s_bus
);

    arb_grant_t grant;
    logic       last_dread;  // last grant went to the read unit
    logic       pick_dread;
    logic       sel_icache;
    logic       sel_dread;

    // on a tie the master that lost last time goes first
    assign pick_dread = m_dread.arvalid && (!m_icache.arvalid || !last_dread);

    always_ff @(posedge clk) begin
        if (rst) begin
            grant      <= grant_none;
            last_dread <= 1'b0;
        end else begin
            case (grant)
                grant_none: begin
                    if (m_icache.arvalid || m_dread.arvalid) begin
                        grant      <= pick_dread ? grant_dread : grant_icache;
                        last_dread <= pick_dread;
                    end
                end
                default: begin
                    // released on the final beat of the granted burst
                    if (s_bus.rvalid && s_bus.rready && s_bus.rlast)
                        grant <= grant_none;
                end
            endcase
        end
    end

    assign sel_icache = (grant == grant_icache);
    assign sel_dread  = (grant == grant_dread);

    assign s_bus.araddr  = sel_dread ? m_dread.araddr : m_icache.araddr;
    assign s_bus.arlen   = sel_dread ? m_dread.arlen  : m_icache.arlen;
    assign s_bus.arsize  = sel_dread ? m_dread.arsize : m_icache.arsize;
    assign s_bus.arvalid = (sel_icache && m_icache.arvalid) || (sel_dread && m_dread.arvalid);
    assign s_bus.rready  = (sel_icache && m_icache.rready) || (sel_dread && m_dread.rready);

    // the master without the grant sees nothing move
    assign m_icache.arready = sel_icache && s_bus.arready;
    assign m_icache.rvalid  = sel_icache && s_bus.rvalid;
    assign m_icache.rdata   = s_bus.rdata;
    assign m_icache.rlast   = s_bus.rlast;

    assign m_dread.arready = sel_dread && s_bus.arready;
    assign m_dread.rvalid  = sel_dread && s_bus.rvalid;
    assign m_dread.rdata   = s_bus.rdata;
    assign m_dread.rlast   = s_bus.rlast;

endmodule

`default_nettype wire

/* rtl/fetch_mem_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_settings.svh"

module fetch_mem_top
    import fetch_pkg::*;
(
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       no_cache,
    input  wire                       inst_en,
    input  wire [`FETCH_ADDR_W-1:0]   pc_next,
    output logic                      stall,
    output logic                      inst_data_ok1,
    output logic                      inst_data_ok2,
    output logic [`FETCH_DATA_W-1:0]  inst_rdata1,
    output logic [`FETCH_DATA_W-1:0]  inst_rdata2,
    input  wire                       load_req,
    input  wire [`FETCH_ADDR_W-1:0]   load_addr,
    output logic                      load_busy,
    output logic                      load_ok,
    output logic [`FETCH_DATA_W-1:0]  load_data,
    output logic [`FETCH_ADDR_W-1:0]  araddr,
    output logic [7:0]                arlen,
    output logic [2:0]                arsize,
    output logic                      arvalid,
    input  wire                       arready,
    input  wire [`FETCH_DATA_W-1:0]   rdata,
    input  wire                       rlast,
    input  wire                       rvalid,
    output logic                      rready
);

    axi_read_if icache_bus ();
    axi_read_if dread_bus ();
    axi_read_if mem_bus ();  // arbiter output, flattened onto the ports

    icache_2way u_icache (
        .clk           (clk),
        .rst           (rst),
        .no_cache      (no_cache),
        .inst_en       (inst_en),
        .pc_next       (pc_next),
        .stall         (stall),
        .inst_data_ok1 (inst_data_ok1),
        .inst_data_ok2 (inst_data_ok2),
        .inst_rdata1   (inst_rdata1),
        .inst_rdata2   (inst_rdata2),
        .bus           (icache_bus.master)
    );

    data_read_unit u_dread (
        .clk       (clk),
        .rst       (rst),
        .load_req  (load_req),
        .load_addr (load_addr),
        .load_busy (load_busy),
        .load_ok   (load_ok),
        .load_data (load_data),
        .bus       (dread_bus.master)
    );

    axi_read_arbiter u_arb (
        .clk      (clk),
        .rst      (rst),
        .m_icache (icache_bus.slave),
        .m_dread  (dread_bus.slave),
        .s_bus    (mem_bus.master)
    );

    assign araddr  = mem_bus.araddr;
    assign arlen   = mem_bus.arlen;
    assign arsize  = mem_bus.arsize;
    assign arvalid = mem_bus.arvalid;
    assign rready  = mem_bus.rready;

    assign mem_bus.arready = arready;
    assign mem_bus.rdata   = rdata;
    assign mem_bus.rlast   = rlast;
    assign mem_bus.rvalid  = rvalid;

endmodule

`default_nettype wire

/* verification/axi_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

// read slave, every word is its own address xor a pattern
module axi_mem_model #(
    parameter logic [31:0] PATTERN  = 32'h5a3c_96e1,
    parameter int          MAX_WAIT = 3  // longest gap before a beat
) (
    input  wire         clk,
    input  wire         rst,
    input  wire  [31:0] araddr,
    input  wire  [7:0]  arlen,
    input  wire         arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic        rlast,
    output logic        rvalid,
    input  wire         rready
);

    logic        busy;
    logic [31:0] addr;  // address of the next beat
    logic [7:0]  left;  // beats after the current one
    int          gap;

    assign arready = !busy;  // one burst at a time

    always @(posedge clk) begin
        if (rst) begin
            busy   <= 1'b0;
            rvalid <= 1'b0;
            rlast  <= 1'b0;
            rdata  <= '0;
            gap    <= 0;
        end else if (!busy) begin
            if (arvalid) begin
                busy <= 1'b1;
                addr <= araddr;
                left <= arlen;
                gap  <= $urandom_range(MAX_WAIT, 0);
            end
        end else if (rvalid) begin
            if (rready) begin
                rvalid <= 1'b0;
                rlast  <= 1'b0;
                addr   <= addr + 32'd4;  // incrementing burst
                left   <= left - 8'd1;
                gap    <= $urandom_range(MAX_WAIT, 0);
                if (rlast)
                    busy <= 1'b0;
            end
        end else if (gap != 0) begin
            gap <= gap - 1;
        end else begin
            rvalid <= 1'b1;
            rdata  <= {addr[31:2], 2'b00} ^ PATTERN;
            rlast  <= (left == 8'd0);
        end
    end

endmodule

`default_nettype wire

/* verification/fetch_mem_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_settings.svh"

module fetch_mem_tb;

    localparam int          CLK_PERIOD  = 20;
    localparam int          MAX_WAIT    = 3;
    localparam logic [31:0] MEM_PATTERN = 32'h5a3c_96e1;
    localparam int          RNG_SEED    = 32'h0b43_38cf;

    localparam int N_COLD  = 4;   // cold lines, three fetches each
    localparam int N_MIX   = 12;  // fetches with loads alongside
    localparam int N_LOADS = 12;
    localparam int N_FETCH = 3 * N_COLD + 2 + 6 + N_MIX;

    // a refill queued behind a load with every gap at its longest, doubled
    localparam int WORST_CYCLES = 2 * (`FETCH_LINE_WORDS + 1) * (MAX_WAIT + 2);
    localparam int TIMEOUT_NS   = (N_FETCH + N_LOADS + 8) * WORST_CYCLES * CLK_PERIOD;

    logic        clk = 1'b0;
    logic        rst;
    logic        no_cache;
    logic        inst_en;
    logic [31:0] pc_next;
    logic        stall;
    logic        inst_data_ok1;
    logic        inst_data_ok2;
    logic [31:0] inst_rdata1;
    logic [31:0] inst_rdata2;
    logic        load_req;
    logic [31:0] load_addr;
    logic        load_busy;
    logic        load_ok;
    logic [31:0] load_data;
    logic [31:0] araddr;
    logic [7:0]  arlen;
    logic [2:0]  arsize;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic        rlast;
    logic        rvalid;
    logic        rready;

    int          errors     = 0;
    int          fetches    = 0;
    int          loads_done = 0;
    int          ar_count   = 0;
    logic        ar_open;       // a burst is between address and last beat
    logic [31:0] last_araddr;
    logic [7:0]  last_arlen;
    logic [31:0] acc_pc;        // pc of the fetch in flight
    logic        acc_nc;
    logic [31:0] acc_load;

    fetch_mem_top DUT (.*);

    axi_mem_model #(.PATTERN(MEM_PATTERN), .MAX_WAIT(MAX_WAIT)) u_mem (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ MEM_PATTERN;
    endfunction

    function automatic logic [31:0] rand_addr(input logic upper_sets);
        logic [31:0] a;
        a      = $urandom;
        a[1:0] = 2'b00;
        a[12]  = upper_sets;  // top index bit, keeps the lru set apart
        return a;
    endfunction

    task automatic note_fail(input string msg);
        errors++;
        $display("FAIL %0t: %s", $time, msg);
    endtask

    // bus and request bookkeeping
    always @(posedge clk) begin
        if (rst) begin
            ar_open <= 1'b0;
        end else begin
            if (arvalid && arready) begin
                ar_open     <= 1'b1;
                ar_count    <= ar_count + 1;
                last_araddr <= araddr;
                last_arlen  <= arlen;
            end
            if (rvalid && rready && rlast)
                ar_open <= 1'b0;
            if (inst_en && !stall) begin
                acc_pc <= pc_next;
                acc_nc <= no_cache;
            end
            if (load_req && !load_busy)
                acc_load <= load_addr;
            if (load_ok)
                loads_done <= loads_done + 1;
        end
    end

    assert property (@(posedge clk) $fell(rst) |->
            !stall && !inst_data_ok1 && !inst_data_ok2 && !load_ok && !arvalid && !rready)
        else note_fail("outputs not quiet after reset");

    // accepted fetch answers in the next cycle or stalls
    assert property (@(posedge clk) disable iff (rst)
            inst_en && !stall |=> inst_data_ok1 || stall)
        else note_fail("accepted fetch neither answered nor stalled");

    assert property (@(posedge clk) disable iff (rst)
            inst_data_ok1 |-> inst_rdata1 == mem_word(acc_pc))
        else note_fail("first fetch word wrong");

    // second word only inside the line, never uncached
    assert property (@(posedge clk) disable iff (rst)
            inst_data_ok1 |-> inst_data_ok2 == (!acc_nc && acc_pc[4:2] != 3'd7))
        else note_fail("second word valid flag wrong");

    assert property (@(posedge clk) disable iff (rst)
            inst_data_ok2 |-> inst_data_ok1 && inst_rdata2 == mem_word(acc_pc + 32'd4))
        else note_fail("second fetch word wrong");

    // one burst at a time on the shared bus
    assert property (@(posedge clk) disable iff (rst) ar_open |-> !arvalid)
        else note_fail("address offered while another burst is open");

    assert property (@(posedge clk) disable iff (rst) arvalid |-> arsize == 3'd2)
        else note_fail("read size is not one 32-bit word");

    assert property (@(posedge clk) disable iff (rst)
            load_ok |-> load_data == mem_word(acc_load))
        else note_fail("load data wrong");

    // starts and ends on a rising edge
    task automatic do_fetch(input logic [31:0] addr, input logic nc,
                            output int latency, output int n_ar);
        int ar_before;
        ar_before = ar_count;
        inst_en  <= 1'b1;
        pc_next  <= addr;
        no_cache <= nc;
        do @(posedge clk); while (stall);
        inst_en <= 1'b0;
        latency = 0;
        do begin
            @(posedge clk);
            latency++;
        end while (!inst_data_ok1);
        n_ar = ar_count - ar_before;
        fetches++;
    endtask

    task automatic check_fetch(input logic [31:0] addr, input logic nc,
                               input logic exp_hit, input string what);
        int          lat;
        int          n_ar;
        logic [31:0] exp_addr;
        logic [7:0]  exp_len;
        do_fetch(addr, nc, lat, n_ar);
        exp_addr = nc ? addr : {addr[31:`FETCH_OFFSET_W], {`FETCH_OFFSET_W{1'b0}}};
        exp_len  = nc ? 8'd0 : 8'(`FETCH_LINE_WORDS - 1);
        if (exp_hit) begin
            assert (lat == 1 && n_ar == 0)
                else note_fail($sformatf("%s %h: expected hit, latency %0d, %0d reads",
                                         what, addr, lat, n_ar));
        end else begin
            assert (lat > 1 && n_ar == 1)
                else note_fail($sformatf("%s %h: expected miss, latency %0d, %0d reads",
                                         what, addr, lat, n_ar));
            assert (last_araddr == exp_addr && last_arlen == exp_len)
                else note_fail($sformatf("%s: read %h len %0d, expected %h len %0d",
                                         what, last_araddr, last_arlen, exp_addr, exp_len));
        end
    endtask

    task automatic issue_load(input logic [31:0] addr);
        load_req  <= 1'b1;
        load_addr <= addr;
        do @(posedge clk); while (load_busy);
        load_req <= 1'b0;
        do @(posedge clk); while (!load_ok);
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        void'($urandom(RNG_SEED));
        rst       = 1'b1;
        no_cache  = 1'b0;
        inst_en   = 1'b0;
        pc_next   = '0;
        load_req  = 1'b0;
        load_addr = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        for (int i = 0; i < N_COLD; i++) begin
            a = rand_addr(1'b0);
            if (i == 0)
                a[4:2] = 3'd7;  // last word of its line
            check_fetch(a, 1'b0, 1'b0, "cold fetch");
            check_fetch(a, 1'b0, 1'b1, "repeat fetch");
            check_fetch(a ^ 32'h4, 1'b0, 1'b1, "neighbour fetch");
        end

        // line of a is cached, the bypass still goes out each time
        check_fetch(a, 1'b1, 1'b0, "uncached fetch");
        check_fetch(a, 1'b1, 1'b0, "uncached repeat");

        a = rand_addr(1'b1);
        b = a ^ (32'd1 << 13);  // same set, other tags
        c = a ^ (32'd2 << 13);
        check_fetch(a, 1'b0, 1'b0, "lru a");
        check_fetch(b, 1'b0, 1'b0, "lru b");
        check_fetch(a, 1'b0, 1'b1, "lru a again");
        check_fetch(c, 1'b0, 1'b0, "lru c");
        check_fetch(a, 1'b0, 1'b1, "lru a kept");
        check_fetch(b, 1'b0, 1'b0, "lru b evicted");

        fork
            for (int i = 0; i < N_MIX; i++) begin
                int lat;
                int n_ar;
                do_fetch(rand_addr(1'b0), 1'b0, lat, n_ar);
            end
            for (int i = 0; i < N_LOADS; i++)
                issue_load(rand_addr(1'b1));
        join

        repeat (4) @(posedge clk);
        assert (loads_done == N_LOADS)
            else note_fail($sformatf("%0d of %0d loads completed", loads_done, N_LOADS));
        $display("fetches %0d, loads %0d of %0d, bus reads %0d, errors %0d",
                 fetches, loads_done, N_LOADS, ar_count, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog: tests did not finish within %0d ns", TIMEOUT_NS);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+rtl
rtl/fetch_pkg.sv
rtl/axi_read_if.sv
rtl/icache_2way.sv
rtl/data_read_unit.sv
rtl/axi_read_arbiter.sv
rtl/fetch_mem_top.sv
verification/axi_mem_model.sv
verification/fetch_mem_tb.sv
